// File: vlog.f
verilog/acq_pkg.sv
verilog/net_pkg.sv
verilog/kdev_decode.sv
verilog/frame_size_calc.sv
verilog/tx_len_result.sv
verilog/acq_frame_sizer.sv
verif/clk_gen.sv
verif/acq_frame_sizer_assertions.sv
verif/tb_acq_frame_sizer.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1

log=sim.log
top=tb_acq_frame_sizer

rm -rf obj_dir
verilator --binary --timing --assert --top-module "$top" -f vlog.f -o sim_"$top"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
    echo "Result: passed"
    exit 0
else
    echo "Result: failed"
    exit 1
fi

// File: verif/tb_acq_frame_sizer.sv
`timescale 1ns/10ps

module tb_acq_frame_sizer;

    import acq_pkg::*;
    import net_pkg::*;

    localparam int payload_bytes = 1472;
    localparam int max_blocks    = 10;
    localparam int fd_timeout    = 40; // Cycles, well above the 15 cycle latency.
    localparam int num_random    = 50;

    logic       clk;
    logic       rst;
    logic [7:0] cmd_kdev;
    logic       fs;
    adc_len_t   adc_rx_len;
    tx_len_t    eth_tx_len;
    logic       fd;

    adc_len_t exp_adc;
    tx_len_t  exp_tx;
    int       errors;
    int       timeouts;
    int       bound_fails;
    int       cases;
    integer   seed;

    clk_gen #(.period_ns(8.0)) u_clk (.clk(clk));

    acq_frame_sizer #(
        .payload_bytes (payload_bytes),
        .max_blocks    (max_blocks)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .cmd_kdev   (cmd_kdev),
        .fs         (fs),
        .adc_rx_len (adc_rx_len),
        .eth_tx_len (eth_tx_len),
        .fd         (fd)
    );

    bind acq_frame_sizer acq_frame_sizer_assertions u_assertions (
        .clk        (clk),
        .rst        (rst),
        .fs         (fs),
        .fd         (fd),
        .adc_rx_len (adc_rx_len),
        .eth_tx_len (eth_tx_len)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    function automatic int block_words(input logic [1:0] code);
        case (code)
            2'd0:    return 0;
            2'd1:    return 32;
            2'd2:    return 64;
            default: return 128;
        endcase
    endfunction

    function automatic int adc_len_of(input logic [7:0] cmd);
        return block_words(cmd[7:6]) + block_words(cmd[5:4])
               + block_words(cmd[3:2]) + block_words(cmd[1:0]) + 6;
    endfunction

    function automatic int tx_len_of(input logic [7:0] cmd);
        int len;
        int blocks;
        len    = adc_len_of(cmd);
        blocks = payload_bytes / len;
        if (blocks > max_blocks) begin
            blocks = max_blocks;
        end
        return blocks * len;
    endfunction

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    // fd is set at edge 15, so the sample at edge 16 is the first to see it.
    latency_a: assert property (@(posedge clk) disable iff (rst) $rose(fs) |-> ##16 $rose(fd))
        else begin
            errors++;
            $display("FAIL %0t: fd did not rise 15 cycles after start", $time);
        end

    fd_hold_a: assert property (@(posedge clk) disable iff (rst) (fd && fs) |=> fd)
        else begin
            errors++;
            $display("FAIL %0t: fd dropped while fs was held", $time);
        end

    fd_release_a: assert property (@(posedge clk) disable iff (rst) (fd && !fs) |=> !fd)
        else begin
            errors++;
            $display("FAIL %0t: fd still high one edge after fs went low", $time);
        end

    adc_len_a: assert property (@(posedge clk) disable iff (rst) fd |-> adc_rx_len == exp_adc)
        else begin
            errors++;
            $display("FAIL %0t: adc_rx_len %0d, expected %0d", $time,
                     $sampled(adc_rx_len), exp_adc);
        end

    tx_len_a: assert property (@(posedge clk) disable iff (rst) fd |-> eth_tx_len == exp_tx)
        else begin
            errors++;
            $display("FAIL %0t: eth_tx_len %0d, expected %0d", $time,
                     $sampled(eth_tx_len), exp_tx);
        end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    task automatic wait_fd(input logic level);
        int n;
        n = 0;
        while (fd !== level && n < fd_timeout) begin
            @(negedge clk);
            n++;
        end
        if (fd !== level) begin
            timeouts++;
            $display("Timeout at %0t: fd did not go to %0b within %0d cycles",
                     $time, level, fd_timeout);
        end
    endtask

    // One full request with the level handshake.
    task automatic run_case(input logic [7:0] cmd, input adc_len_t adc, input tx_len_t tx);
        @(negedge clk);
        cmd_kdev = cmd; // Command is set up before start.
        exp_adc  = adc;
        exp_tx   = tx;
        @(negedge clk);
        fs = 1'b1;
        wait_fd(1'b1);
        repeat (3) @(negedge clk); // Done has to stay up meanwhile.
        fs = 1'b0;
        wait_fd(1'b0);
        repeat (2) @(negedge clk);
        cases++;
    endtask

    initial begin
        logic [7:0] cmd;
        rst         = 1'b1;
        fs          = 1'b0;
        cmd_kdev    = 8'h00;
        exp_adc     = '0;
        exp_tx      = '0;
        errors      = 0;
        timeouts    = 0;
        bound_fails = 0;
        cases       = 0;
        seed        = 7563;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_case(8'h00, 10'd6, 12'd60);     // 245 blocks fit, clamped to 10.
        run_case(8'hff, 10'd518, 12'd1036); // Two blocks of 518.

        for (int i = 0; i < num_random; i++) begin
            cmd = 8'($random(seed));
            run_case(cmd, adc_len_t'(adc_len_of(cmd)), tx_len_t'(tx_len_of(cmd)));
        end

        repeat (2) @(negedge clk);
        bound_fails = uut.u_assertions.fail_count;
        $display("Summary: %0d cases, %0d check errors, %0d bound failures, %0d timeouts",
                 cases, errors, bound_fails, timeouts);
        if (errors == 0 && timeouts == 0 && bound_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verif/acq_frame_sizer_assertions.sv
`timescale 1ns/10ps

module acq_frame_sizer_assertions (
    input logic              clk,
    input logic              rst,
    input logic              fs,
    input logic              fd,
    input acq_pkg::adc_len_t adc_rx_len,
    input net_pkg::tx_len_t  eth_tx_len
);

    int fail_count = 0;

    // ------------------------------------------------------------
    // Top-level handshake
    // ------------------------------------------------------------

    // Done comes out of reset low.
    fd_reset_a: assert property (@(posedge clk) rst |=> !fd)
        else begin
            fail_count++;
            $error("fd is high right after reset");
        end

    // Once start is seen low, done must be low on the next sample.
    fd_needs_fs_a: assert property (@(posedge clk) disable iff (rst) !fs |=> !fd)
        else begin
            fail_count++;
            $error("fd is high although fs was sampled low");
        end

    // Results hold for as long as done is up.
    outputs_stable_a: assert property (@(posedge clk) disable iff (rst)
        (fd && $past(fd)) |-> ($stable(adc_rx_len) && $stable(eth_tx_len)))
        else begin
            fail_count++;
            $error("adc_rx_len or eth_tx_len changed while fd was high");
        end

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter real period_ns = 8.0
) (
    output logic clk
);

    always begin
        clk = 1'b0;
        #(period_ns / 2.0);
        clk = 1'b1;
        #(period_ns / 2.0);
    end

endmodule

// File: verilog/acq_frame_sizer.sv
`timescale 1ns/10ps

module acq_frame_sizer #(
    parameter int payload_bytes = 1472,
    parameter int max_blocks    = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        cmd_kdev,
    input  logic              fs,
    output acq_pkg::adc_len_t adc_rx_len,
    output net_pkg::tx_len_t  eth_tx_len,
    output logic              fd
);

    import acq_pkg::*;
    import net_pkg::*;

    logic        blocks_vld;
    dev_blocks_t blocks;
    logic        plan_vld;
    frame_plan_t plan;

    // Decode stage.
    kdev_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .cmd_kdev   (cmd_kdev),
        .fs         (fs),
        .blocks_vld (blocks_vld),
        .blocks     (blocks)
    );

    // Length sum and divide.
    frame_size_calc #(
        .payload_bytes (payload_bytes)
    ) u_calc (
        .clk        (clk),
        .rst        (rst),
        .blocks_vld (blocks_vld),
        .blocks     (blocks),
        .plan_vld   (plan_vld),
        .plan       (plan)
    );

    // Clamp, multiply and handshake.
    tx_len_result #(
        .max_blocks (max_blocks)
    ) u_result (
        .clk        (clk),
        .rst        (rst),
        .plan_vld   (plan_vld),
        .plan       (plan),
        .fs         (fs),
        .adc_rx_len (adc_rx_len),
        .eth_tx_len (eth_tx_len),
        .fd         (fd)
    );

endmodule

// File: verilog/tx_len_result.sv
`timescale 1ns/10ps

module tx_len_result #(
    parameter int max_blocks = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 plan_vld,
    input  net_pkg::frame_plan_t plan,
    input  logic                 fs,
    output acq_pkg::adc_len_t    adc_rx_len,
    output net_pkg::tx_len_t     eth_tx_len,
    output logic                 fd
);

    import net_pkg::*;

    localparam blk_cnt_t blk_limit = blk_cnt_t'(max_blocks);

    blk_cnt_t blk_cnt;
    tx_len_t  tx_len;

    // Clamp the block count, then size the frame.
    always_comb begin
        blk_cnt = (plan.quotient > blk_limit) ? blk_limit : plan.quotient;
        tx_len  = tx_len_t'(blk_cnt) * tx_len_t'(plan.adc_len);
    end

    // ------------------------------------------------------------
    // Output registers and done handshake
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            adc_rx_len <= '0;
            eth_tx_len <= '0;
        end else if (plan_vld) begin
            adc_rx_len <= plan.adc_len;
            eth_tx_len <= tx_len;
        end
    end

    // Done follows the level protocol.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd <= 1'b0;
        end else if (!fs) begin
            fd <= 1'b0; // Requester released start.
        end else if (plan_vld) begin
            fd <= 1'b1;
        end
    end

endmodule

// File: verilog/frame_size_calc.sv
`timescale 1ns/10ps

module frame_size_calc #(
    parameter int payload_bytes = 1472
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 blocks_vld,
    input  acq_pkg::dev_blocks_t blocks,
    output logic                 plan_vld,
    output net_pkg::frame_plan_t plan
);

    import acq_pkg::*;
    import net_pkg::*;

    // One quotient bit per dividend bit.
    localparam int div_steps = $bits(tx_len_t);

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------

    logic       busy;
    logic [3:0] step;
    logic       last_step;

    assign last_step = (step == 4'(div_steps - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            step     <= 4'd0;
            plan_vld <= 1'b0;
        end else begin
            plan_vld <= 1'b0;
            if (blocks_vld) begin
                busy <= 1'b1;
                step <= 4'd0;
            end else if (busy) begin
                step <= step + 4'd1;
                if (last_step) begin
                    busy     <= 1'b0;
                    plan_vld <= 1'b1; // Quotient complete this edge.
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Length sum and restoring divider
    // ------------------------------------------------------------

    adc_len_t    adc_len;   // Divisor, never below the header size.
    adc_len_t    rem;       // Partial remainder.
    tx_len_t     quo;       // Dividend shifts out, quotient shifts in.
    logic [10:0] trial;
    logic [10:0] diff;
    logic        fits;

    always_comb begin
        trial = {rem, quo[div_steps-1]};
        diff  = trial - {1'b0, adc_len};
        fits  = (trial >= {1'b0, adc_len});
    end

    always_ff @(posedge clk) begin
        if (blocks_vld) begin
            adc_len <= blocks.dev0 + blocks.dev1 + blocks.dev2 + blocks.dev3
                       + adc_hdr_words;
            rem     <= '0;
            quo     <= tx_len_t'(payload_bytes);
        end else if (busy) begin
            rem <= fits ? diff[9:0] : trial[9:0]; // Restore when it does not fit.
            quo <= {quo[div_steps-2:0], fits};
        end
    end

    always_comb begin
        plan.adc_len  = adc_len;
        plan.quotient = sat_blk_cnt(quo);
    end

endmodule

// File: verilog/kdev_decode.sv
`timescale 1ns/10ps

module kdev_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          cmd_kdev,
    input  logic                fs,
    output logic                blocks_vld,
    output acq_pkg::dev_blocks_t blocks
);

    import acq_pkg::*;

    logic       fs_q;
    logic       start_q;
    logic [7:0] cmd_q;

    // Block size for one device code.
    function automatic adc_len_t code_len(input dev_code_t code);
        case (code)
            dev_off:    return 10'd0;
            dev_blk_32: return 10'd32;
            dev_blk_64: return 10'd64;
            default:    return 10'd128;
        endcase
    endfunction

    // Start edge detect and strobe timing.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_q       <= 1'b0;
            start_q    <= 1'b0;
            blocks_vld <= 1'b0;
        end else begin
            fs_q       <= fs;
            start_q    <= fs & ~fs_q; // Rising edge of fs.
            blocks_vld <= start_q;
        end
    end

    // Command capture and expansion.
    always_ff @(posedge clk) begin
        if (fs & ~fs_q) begin
            cmd_q <= cmd_kdev;
        end
        if (start_q) begin
            blocks.dev0 <= code_len(cmd_q[7:6]);
            blocks.dev1 <= code_len(cmd_q[5:4]);
            blocks.dev2 <= code_len(cmd_q[3:2]);
            blocks.dev3 <= code_len(cmd_q[1:0]);
        end
    end

endmodule

// File: verilog/net_pkg.sv
package net_pkg;

    // ------------------------------------------------------------
    // Ethernet transmit sizing
    // ------------------------------------------------------------

    // Transmit length in bytes; must also hold the UDP payload size.
    typedef logic [11:0] tx_len_t;

    // Number of ADC blocks packed into one frame.
    typedef logic [7:0] blk_cnt_t;

    localparam blk_cnt_t blk_cnt_max = 8'hff; // Quotient saturates here.

    // ------------------------------------------------------------
    // Frame plan
    // ------------------------------------------------------------

    // Result of the divide stage, one per start request.
    typedef struct packed {
        acq_pkg::adc_len_t adc_len;  // ADC receive length incl. header.
        blk_cnt_t          quotient; // Blocks that fit the payload.
    } frame_plan_t;

    // Saturate a wide quotient into a block count.
    function automatic blk_cnt_t sat_blk_cnt(input tx_len_t q);
        if (q > tx_len_t'(blk_cnt_max)) return blk_cnt_max;
        return blk_cnt_t'(q);
    endfunction

endpackage

// File: verilog/acq_pkg.sv
package acq_pkg;

    // ------------------------------------------------------------
    // Device codes
    // ------------------------------------------------------------

    // 0 is off, 1/2/3 pick a block of 32/64/128 words.
    typedef logic [1:0] dev_code_t;

    localparam dev_code_t dev_off    = 2'd0;
    localparam dev_code_t dev_blk_32 = 2'd1;
    localparam dev_code_t dev_blk_64 = 2'd2;

    // ------------------------------------------------------------
    // ADC receive lengths
    // ------------------------------------------------------------

    typedef logic [9:0] adc_len_t; // Words.

    localparam adc_len_t adc_hdr_words = 10'd6; // Fixed header ahead of the samples.

    // Per-device block sizes; dev0 comes from cmd_kdev[7:6].
    typedef struct packed {
        adc_len_t dev0;
        adc_len_t dev1;
        adc_len_t dev2;
        adc_len_t dev3;
    } dev_blocks_t;

endpackage
